/* include/pcw_mmu_params.svh */
/*
 * PCW memory-mapping unit constants
 * Port numbers, register reset values, widths and memory-size codes
 */
`ifndef PCW_MMU_PARAMS_SVH
`define PCW_MMU_PARAMS_SVH

// I/O ports of the mapping registers
`define PCW_PORT_F0 8'hF0   // Page map 0000-3FFF
`define PCW_PORT_F1 8'hF1   // Page map 4000-7FFF
`define PCW_PORT_F2 8'hF2   // Page map 8000-BFFF
`define PCW_PORT_F3 8'hF3   // Page map C000-FFFF
`define PCW_PORT_F4 8'hF4   // CPC read lock

// Power-up mapping is bank q in quadrant q, PCW mode
`define PCW_F0_RESET 8'h80
`define PCW_F1_RESET 8'h81
`define PCW_F2_RESET 8'h82
`define PCW_F3_RESET 8'h83
`define PCW_F4_RESET 8'hF1  // All quadrants locked

// Offset inside a 16K page
`define PCW_OFFSET_W 14

// Memory size codes
`define PCW_MEM_256K 2'd0
`define PCW_MEM_512K 2'd1
`define PCW_MEM_1M   2'd2
`define PCW_MEM_2M   2'd3

`endif

/* verilog/pcw_mmu_pkg.sv */
/*
 * PCW memory-mapping unit types
 * Vector typedefs for addresses, register bytes, banks and size codes
 */
`default_nettype none

`include "pcw_mmu_params.svh"

package pcw_mmu_pkg;

    // CPU side
    typedef logic [15:0] cpu_addr_t;    // Z80 address bus
    typedef logic [7:0]  io_port_t;     // Low byte of the I/O address

    // Page or lock byte as written by the CPU
    typedef logic [7:0] page_reg_t;

    // Bank number in 16K units, up to 128 banks for 2M
    typedef logic [6:0] bank_t;

    // Offset within a page
    typedef logic [`PCW_OFFSET_W-1:0] offset_t;

    // Physical address is bank then offset
    typedef logic [20:0] phys_addr_t;

    // 256K, 512K, 1M or 2M
    typedef logic [1:0] mem_size_t;

endpackage

`default_nettype wire

/* verilog/page_port_regs.sv */
/*
 * Mapping register file for ports F0-F4
 * Four page bytes and the CPC read lock, written by I/O strobes
 */
`timescale 1ns/1ps
`default_nettype none

`include "pcw_mmu_params.svh"

module page_port_regs (
    input  logic                   clk_sys,
    input  logic                   reset,

    // CPU I/O write
    input  logic                   io_wr,      // One-cycle strobe
    input  pcw_mmu_pkg::io_port_t  io_port,
    input  pcw_mmu_pkg::page_reg_t io_data,

    // Current mapping
    output pcw_mmu_pkg::page_reg_t page_f0,
    output pcw_mmu_pkg::page_reg_t page_f1,
    output pcw_mmu_pkg::page_reg_t page_f2,
    output pcw_mmu_pkg::page_reg_t page_f3,
    output pcw_mmu_pkg::page_reg_t lock_f4
);

    // Port decode
    logic sel_f0;
    logic sel_f1;
    logic sel_f2;
    logic sel_f3;
    logic sel_f4;

    assign sel_f0 = io_wr && (io_port == `PCW_PORT_F0);
    assign sel_f1 = io_wr && (io_port == `PCW_PORT_F1);
    assign sel_f2 = io_wr && (io_port == `PCW_PORT_F2);
    assign sel_f3 = io_wr && (io_port == `PCW_PORT_F3);
    assign sel_f4 = io_wr && (io_port == `PCW_PORT_F4);

    // New value visible the cycle after the strobe
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            page_f0 <= `PCW_F0_RESET;
            page_f1 <= `PCW_F1_RESET;
            page_f2 <= `PCW_F2_RESET;
            page_f3 <= `PCW_F3_RESET;
            lock_f4 <= `PCW_F4_RESET;
        end else begin
            if (sel_f0) page_f0 <= io_data;    // 0000-3FFF
            if (sel_f1) page_f1 <= io_data;    // 4000-7FFF
            if (sel_f2) page_f2 <= io_data;    // 8000-BFFF
            if (sel_f3) page_f3 <= io_data;    // C000-FFFF

            // Only bits 7:4 matter downstream but the whole byte is kept
            if (sel_f4) lock_f4 <= io_data;
        end
    end

    // Any other port leaves the map alone

endmodule

`default_nettype wire

/* verilog/bank_select_stage.sv */
/*
 * Pipeline stage 1 of the mapping unit
 * Picks the page byte and lock bit of the addressed quadrant
 */
`timescale 1ns/1ps
`default_nettype none

`include "pcw_mmu_params.svh"

module bank_select_stage (
    input  logic                   clk_sys,
    input  logic                   reset,

    // Memory request from the CPU side
    input  logic                   mem_req,    // One-cycle strobe
    input  pcw_mmu_pkg::cpu_addr_t mem_addr,
    input  logic                   mem_wr,

    // Mapping registers
    input  pcw_mmu_pkg::page_reg_t page_f0,
    input  pcw_mmu_pkg::page_reg_t page_f1,
    input  pcw_mmu_pkg::page_reg_t page_f2,
    input  pcw_mmu_pkg::page_reg_t page_f3,
    input  pcw_mmu_pkg::page_reg_t lock_f4,

    // To stage 2
    output logic                   s1_valid,
    output pcw_mmu_pkg::page_reg_t s1_page,
    output logic                   s1_lock,
    output pcw_mmu_pkg::offset_t   s1_offset,
    output logic                   s1_wr
);

    logic [1:0]             quad;      // 16K quadrant of the CPU map
    pcw_mmu_pkg::page_reg_t page_sel;
    logic                   lock_sel;

    assign quad = mem_addr[15:`PCW_OFFSET_W];

    // Lock bits sit in F4 bits 7:4, one per quadrant
    always_comb begin
        case (quad)
            2'd0: begin
                page_sel = page_f0;
                lock_sel = lock_f4[4];
            end
            2'd1: begin
                page_sel = page_f1;
                lock_sel = lock_f4[5];
            end
            2'd2: begin
                page_sel = page_f2;
                lock_sel = lock_f4[6];
            end
            default: begin
                page_sel = page_f3;
                lock_sel = lock_f4[7];
            end
        endcase
    end

    // Valid bit
    always_ff @(posedge clk_sys) begin
        if (reset) s1_valid <= 1'b0;
        else       s1_valid <= mem_req;
    end

    // Snapshot of the registers in the request cycle
    always_ff @(posedge clk_sys) begin
        if (mem_req) begin
            s1_page   <= page_sel;
            s1_lock   <= lock_sel;
            s1_offset <= mem_addr[`PCW_OFFSET_W-1:0];   // Passes straight through
            s1_wr     <= mem_wr;
        end
    end

endmodule

`default_nettype wire

/* verilog/addr_translate_stage.sv */
/*
 * Pipeline stage 2 of the mapping unit
 * PCW or CPC paging with size mask, external region flag, output register
 */
`timescale 1ns/1ps
`default_nettype none

`include "pcw_mmu_params.svh"

module addr_translate_stage (
    input  logic                    clk_sys,
    input  logic                    reset,

    // From stage 1
    input  logic                    s1_valid,
    input  pcw_mmu_pkg::page_reg_t  s1_page,
    input  logic                    s1_lock,
    input  pcw_mmu_pkg::offset_t    s1_offset,
    input  logic                    s1_wr,

    // Fitted memory, a level
    input  pcw_mmu_pkg::mem_size_t  memory_size,

    // Translated request
    output logic                    phys_valid,
    output pcw_mmu_pkg::phys_addr_t phys_addr,
    output logic                    phys_wr,
    output logic                    ext_sel
);

    pcw_mmu_pkg::bank_t      pcw_bank;     // Bit 7 set
    pcw_mmu_pkg::bank_t      cpc_bank;     // Bit 7 clear
    pcw_mmu_pkg::bank_t      bank;
    logic [2:0]              cpc_field;
    pcw_mmu_pkg::phys_addr_t addr_next;
    logic                    ext_next;

    // PCW mode masks the page byte to the fitted memory
    always_comb begin
        case (memory_size)
            `PCW_MEM_256K: pcw_bank = {3'b000, s1_page[3:0]};  // 16 banks
            `PCW_MEM_512K: pcw_bank = {2'b00, s1_page[4:0]};   // 32 banks
            `PCW_MEM_1M:   pcw_bank = {1'b0, s1_page[5:0]};    // 64 banks
            default:       pcw_bank = s1_page[6:0];            // 2M, 128 banks
        endcase
    end

    // CPC mode
    // Writes always use bits 2:0
    // Reads use bits 2:0 when locked and bits 6:4 otherwise
    assign cpc_field = (s1_wr || s1_lock) ? s1_page[2:0] : s1_page[6:4];
    assign cpc_bank  = {4'b0000, cpc_field};  // Stays in the first 128K

    assign bank = s1_page[7] ? pcw_bank : cpc_bank;

    assign addr_next = {bank, s1_offset};

    // Anything above the first 128K is external memory
    assign ext_next = |addr_next[20:17];

    // Valid follows stage 1 by one edge
    always_ff @(posedge clk_sys) begin
        if (reset) phys_valid <= 1'b0;
        else       phys_valid <= s1_valid;
    end

    // Result held until the next request
    always_ff @(posedge clk_sys) begin
        if (s1_valid) begin
            phys_addr <= addr_next;
            phys_wr   <= s1_wr;
            ext_sel   <= ext_next;    // Kept in step with phys_addr
        end
    end

endmodule

`default_nettype wire

/* verilog/pcw_mmu_top.sv */
/*
 * PCW memory-mapping unit top level
 * Register file feeding a two-stage address translation pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module pcw_mmu_top (
    input  logic                    clk_sys,
    input  logic                    reset,

    // I/O writes to ports F0-F4
    input  logic                    io_wr,
    input  pcw_mmu_pkg::io_port_t   io_port,
    input  pcw_mmu_pkg::page_reg_t  io_data,

    // Memory requests
    input  logic                    mem_req,
    input  pcw_mmu_pkg::cpu_addr_t  mem_addr,
    input  logic                    mem_wr,
    input  pcw_mmu_pkg::mem_size_t  memory_size,

    // Physical side, two cycles after mem_req
    output logic                    phys_valid,
    output pcw_mmu_pkg::phys_addr_t phys_addr,
    output logic                    phys_wr,
    output logic                    ext_sel
);

    // Register file to stage 1
    pcw_mmu_pkg::page_reg_t page_f0;
    pcw_mmu_pkg::page_reg_t page_f1;
    pcw_mmu_pkg::page_reg_t page_f2;
    pcw_mmu_pkg::page_reg_t page_f3;
    pcw_mmu_pkg::page_reg_t lock_f4;

    // Stage 1 to stage 2
    logic                   s1_valid;
    pcw_mmu_pkg::page_reg_t s1_page;
    logic                   s1_lock;
    pcw_mmu_pkg::offset_t   s1_offset;
    logic                   s1_wr;

    page_port_regs i_page_port_regs (
        .clk_sys (clk_sys),
        .reset   (reset),
        .io_wr   (io_wr),
        .io_port (io_port),
        .io_data (io_data),
        .page_f0 (page_f0),
        .page_f1 (page_f1),
        .page_f2 (page_f2),
        .page_f3 (page_f3),
        .lock_f4 (lock_f4)
    );

    // Quadrant select and snapshot
    bank_select_stage i_bank_select_stage (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wr    (mem_wr),
        .page_f0   (page_f0),
        .page_f1   (page_f1),
        .page_f2   (page_f2),
        .page_f3   (page_f3),
        .lock_f4   (lock_f4),
        .s1_valid  (s1_valid),
        .s1_page   (s1_page),
        .s1_lock   (s1_lock),
        .s1_offset (s1_offset),
        .s1_wr     (s1_wr)
    );

    // Paging mode and size mask
    addr_translate_stage i_addr_translate_stage (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .s1_valid    (s1_valid),
        .s1_page     (s1_page),
        .s1_lock     (s1_lock),
        .s1_offset   (s1_offset),
        .s1_wr       (s1_wr),
        .memory_size (memory_size),
        .phys_valid  (phys_valid),
        .phys_addr   (phys_addr),
        .phys_wr     (phys_wr),
        .ext_sel     (ext_sel)
    );

endmodule

`default_nettype wire

/* dv/pcw_mmu_assertions.sv */
/*
 * Bound checker for the memory-mapping unit
 * Shadow page registers, two-deep request record, output assertions
 */
`timescale 1ns/1ps
`default_nettype none

`include "pcw_mmu_params.svh"

module pcw_mmu_assertions (
    input logic                    clk_sys,
    input logic                    reset,
    input logic                    io_wr,
    input pcw_mmu_pkg::io_port_t   io_port,
    input pcw_mmu_pkg::page_reg_t  io_data,
    input logic                    mem_req,
    input pcw_mmu_pkg::cpu_addr_t  mem_addr,
    input logic                    mem_wr,
    input pcw_mmu_pkg::mem_size_t  memory_size,
    input logic                    phys_valid,
    input pcw_mmu_pkg::phys_addr_t phys_addr,
    input logic                    phys_wr,
    input logic                    ext_sel
);

    pcw_mmu_pkg::page_reg_t  shadow_page [4];   // Copy of F0-F3
    pcw_mmu_pkg::page_reg_t  shadow_lock;       // Copy of F4
    logic                    rec_valid;         // Request taken on the last edge
    pcw_mmu_pkg::page_reg_t  rec_page;
    logic                    rec_lock;
    pcw_mmu_pkg::offset_t    rec_offset;
    logic                    rec_wr;
    logic                    exp_valid;         // Result due now
    pcw_mmu_pkg::phys_addr_t exp_addr;
    logic                    exp_wr;

    // Failure counts, summed by the testbench
    int unsigned n_valid_err = 0;
    int unsigned n_addr_err  = 0;
    int unsigned n_ext_err   = 0;

    // Bank number straight from the paging rules
    function automatic pcw_mmu_pkg::bank_t bank_of(input pcw_mmu_pkg::page_reg_t page,
            input logic lock, input logic wr, input pcw_mmu_pkg::mem_size_t size);
        logic [6:0] keep;
        keep = 7'h7F >> (2'd3 - size);              // 4, 5, 6 or 7 low bits
        if (page[7]) return page[6:0] & keep;       // PCW
        else if (wr || lock) return {4'd0, page[2:0]};
        else return {4'd0, page[6:4]};              // Unlocked CPC read
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            shadow_page[0] <= `PCW_F0_RESET;
            shadow_page[1] <= `PCW_F1_RESET;
            shadow_page[2] <= `PCW_F2_RESET;
            shadow_page[3] <= `PCW_F3_RESET;
            shadow_lock    <= `PCW_F4_RESET;
        end else if (io_wr) begin
            if (io_port == `PCW_PORT_F4) shadow_lock <= io_data;
            else if (io_port[7:2] == 6'b111100) shadow_page[io_port[1:0]] <= io_data;  // F0-F3
        end
    end

    // Two requests in flight at most
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rec_valid <= 1'b0;
            exp_valid <= 1'b0;
        end else begin
            rec_valid <= mem_req;
            exp_valid <= rec_valid;
        end
        if (mem_req) begin
            rec_page   <= shadow_page[mem_addr[15:14]];          // Old value on a same-cycle write
            rec_lock   <= shadow_lock[{1'b1, mem_addr[15:14]}];  // F4 bits 7:4
            rec_offset <= mem_addr[13:0];
            rec_wr     <= mem_wr;
        end
        if (rec_valid) begin
            exp_addr <= {bank_of(rec_page, rec_lock, rec_wr, memory_size), rec_offset};
            exp_wr   <= rec_wr;
        end
    end

    valid_timing: assert property (@(posedge clk_sys) disable iff (reset)
        phys_valid == exp_valid)
        else begin
            $error("** Error at %0t: phys_valid %b, expected %b", $time, phys_valid, exp_valid);
            n_valid_err = n_valid_err + 1;
        end

    addr_match: assert property (@(posedge clk_sys) disable iff (reset)
        exp_valid |-> (phys_addr == exp_addr && phys_wr == exp_wr))
        else begin
            $error("** Error at %0t: phys_addr %h wr %b, expected %h wr %b",
                $time, phys_addr, phys_wr, exp_addr, exp_wr);
            n_addr_err = n_addr_err + 1;
        end

    // Anything past the first 128K of the expected address
    ext_region: assert property (@(posedge clk_sys) disable iff (reset)
        exp_valid |-> (ext_sel == (exp_addr[20:17] != 4'd0)))
        else begin
            $error("** Error at %0t: ext_sel %b, expected %b for address %h",
                $time, ext_sel, (exp_addr[20:17] != 4'd0), exp_addr);
            n_ext_err = n_ext_err + 1;
        end

endmodule

bind pcw_mmu_top pcw_mmu_assertions i_assertions (.*);

`default_nettype wire

/* dv/pcw_mmu_tb.sv */
/*
 * Testbench for the PCW memory-mapping unit
 * Seeded random port writes and requests, checked by the bound assertions
 */
`timescale 1ns/1ps
`default_nettype none

`include "pcw_mmu_params.svh"

module pcw_mmu_tb;

    localparam int unsigned DRAIN_LIMIT = 50;   // Cycles allowed for results to come back

    logic                    clk_sys;
    logic                    reset;
    logic                    io_wr;
    pcw_mmu_pkg::io_port_t   io_port;
    pcw_mmu_pkg::page_reg_t  io_data;
    logic                    mem_req;
    pcw_mmu_pkg::cpu_addr_t  mem_addr;
    logic                    mem_wr;
    pcw_mmu_pkg::mem_size_t  memory_size;
    logic                    phys_valid;
    pcw_mmu_pkg::phys_addr_t phys_addr;
    logic                    phys_wr;
    logic                    ext_sel;

    int unsigned req_count;    // Requests issued
    int unsigned resp_count;   // phys_valid pulses seen

    pcw_mmu_top i_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;   // 100 MHz
    end

    always @(posedge clk_sys) begin
        if (reset) resp_count <= 0;
        else if (phys_valid) resp_count <= resp_count + 1;
    end

    function automatic int unsigned assertion_failures();
        return i_dut.i_assertions.n_valid_err + i_dut.i_assertions.n_addr_err
            + i_dut.i_assertions.n_ext_err;
    endfunction

    // First failed assertion ends the run
    always @(negedge clk_sys) begin
        if (assertion_failures() != 0) begin
            $display("Done: errors found");
            $fatal(1, "An output assertion failed by %0t", $time);
        end
    end

    function automatic pcw_mmu_pkg::page_reg_t rand_byte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    // Random offset inside the given quadrant
    function automatic pcw_mmu_pkg::cpu_addr_t rand_addr(input logic [1:0] quad);
        logic [31:0] r;
        r = $urandom();
        return {quad, r[13:0]};
    endfunction

    function automatic pcw_mmu_pkg::io_port_t port_of(input logic [2:0] sel);
        case (sel)
            3'd0:    return `PCW_PORT_F0;
            3'd1:    return `PCW_PORT_F1;
            3'd2:    return `PCW_PORT_F2;
            3'd3:    return `PCW_PORT_F3;
            3'd4:    return `PCW_PORT_F4;
            3'd5:    return 8'hF8;   // Not a map port
            default: return 8'h7F;
        endcase
    endfunction

    // One clock of stimulus, strobes drop on the next call
    task automatic drive_cycle(input logic wr_io, input pcw_mmu_pkg::io_port_t port,
            input pcw_mmu_pkg::page_reg_t data, input logic req,
            input pcw_mmu_pkg::cpu_addr_t addr, input logic wr);
        @(posedge clk_sys);
        io_wr    <= wr_io;
        io_port  <= port;
        io_data  <= data;
        mem_req  <= req;
        mem_addr <= addr;
        mem_wr   <= wr;
        if (req) req_count++;
    endtask

    task automatic io_write(input pcw_mmu_pkg::io_port_t port, input pcw_mmu_pkg::page_reg_t data);
        drive_cycle(1'b1, port, data, 1'b0, 16'h0000, 1'b0);
    endtask

    task automatic mem_request(input pcw_mmu_pkg::cpu_addr_t addr, input logic wr);
        drive_cycle(1'b0, 8'h00, 8'h00, 1'b1, addr, wr);
    endtask

    // Idle until every request has produced its phys_valid
    task automatic wait_drain(input string what);
        int unsigned n;
        n = 0;
        drive_cycle(1'b0, 8'h00, 8'h00, 1'b0, 16'h0000, 1'b0);
        while (resp_count != req_count && n < DRAIN_LIMIT) begin
            @(posedge clk_sys);
            n++;
        end
        if (resp_count != req_count) begin
            $display("Done: errors found");
            $fatal(1, "Timeout: %s left requests without a phys_valid response", what);
        end
    endtask

    task automatic set_size(input pcw_mmu_pkg::mem_size_t size);
        wait_drain("memory size change");
        @(posedge clk_sys);
        memory_size <= size;   // Only with the pipeline empty
    endtask

    initial begin
        logic [31:0] r;
        int unsigned i;
        int unsigned k;

        reset       = 1'b1;
        io_wr       = 1'b0;
        io_port     = 8'h00;
        io_data     = 8'h00;
        mem_req     = 1'b0;
        mem_addr    = 16'h0000;
        mem_wr      = 1'b0;
        memory_size = `PCW_MEM_2M;
        req_count   = 0;
        r = $urandom(32'h7ae1_5a15);   // Seeds the whole run
        repeat (10) @(posedge clk_sys);
        reset <= 1'b0;

        // Power-up map, quadrant q to bank q
        for (i = 0; i < 16; i++) begin
            mem_request(rand_addr(i[1:0]), i[2]);
        end
        wait_drain("reset mapping");

        // PCW paging under every size code
        for (k = 0; k < 4; k++) begin
            set_size(k[1:0]);
            for (i = 0; i < 12; i++) begin
                r = $urandom();
                io_write(port_of({1'b0, r[1:0]}), rand_byte() | 8'h80);
                mem_request(rand_addr(r[1:0]), r[2]);
                mem_request(rand_addr(r[3:2]), r[4]);   // Often another quadrant
            end
            wait_drain("PCW paging");
        end

        // CPC paging with no lock, full lock, then random locks
        for (k = 0; k < 4; k++) begin
            r = $urandom();
            io_write(`PCW_PORT_F4, (k == 0) ? 8'h00 : (k == 1) ? 8'hF0 : r[31:24]);
            for (i = 0; i < 8; i++) begin
                r = $urandom();
                io_write(port_of({1'b0, r[1:0]}), rand_byte() & 8'h7F);
                mem_request(rand_addr(r[1:0]), 1'b0);
                mem_request(rand_addr(r[1:0]), 1'b1);
            end
        end
        wait_drain("CPC paging");

        // Back-to-back requests, port writes in the same cycle
        for (k = 0; k < 6; k++) begin
            r = $urandom();
            set_size(r[1:0]);
            for (i = 0; i < 32; i++) begin
                r = $urandom();
                drive_cycle(r[3], port_of(r[6:4]), r[15:8], r[16] | r[17],
                    rand_addr(r[19:18]), r[20]);
            end
            wait_drain("back-to-back requests");
        end

        if (assertion_failures() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Output assertions failed");
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
verilog/pcw_mmu_pkg.sv
verilog/page_port_regs.sv
verilog/bank_select_stage.sv
verilog/addr_translate_stage.sv
verilog/pcw_mmu_top.sv
dv/pcw_mmu_assertions.sv
dv/pcw_mmu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the mapping unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module pcw_mmu_tb -Mdir obj_dir -o pcw_mmu_sim -f files.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status" >&2
    exit "$status"
fi

# Let the testbench see the first failed assertion before it stops the run
./obj_dir/pcw_mmu_sim +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status" >&2
    exit "$status"
fi

exit 0
